// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := kabuki_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) sim/kabuki_ref.svh
PASS_MSG  := No errors

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+sim
verilog/kabuki_pkg.sv
verilog/kabuki_key_loader.sv
verilog/kabuki_addr_hash.sv
verilog/kabuki_byte_decrypt.sv
verilog/kabuki_decoder_top.sv
sim/kabuki_tb.sv

// ==== sim/kabuki_ref.svh ====
// reference functions for the kabuki hash and cipher, included inside the testbench module.
`ifndef KABUKI_REF_SVH
`define KABUKI_REF_SVH

// address hash, opcode form when m1_n is low and data form otherwise.
function automatic logic [15:0] ref_hash(input logic m1_n, input logic [15:0] addr,
                                         input logic [15:0] addr_key);
    if (m1_n) return (addr ^ kabuki_pkg::data_addr_mask) + addr_key + 16'd1;
    return addr + addr_key;
endfunction

// pair swap with nibble three on the top pair.
function automatic logic [7:0] ref_swap_fwd(input logic [7:0] b, input logic [15:0] k,
                                            input logic [7:0] h);
    return {h[k[14:12]] ? {b[6], b[7]} : b[7:6],
            h[k[10:8]]  ? {b[4], b[5]} : b[5:4],
            h[k[6:4]]   ? {b[2], b[3]} : b[3:2],
            h[k[2:0]]   ? {b[0], b[1]} : b[1:0]};
endfunction

// pair swap with nibble zero on the top pair.
function automatic logic [7:0] ref_swap_rev(input logic [7:0] b, input logic [15:0] k,
                                            input logic [7:0] h);
    return {h[k[2:0]]   ? {b[6], b[7]} : b[7:6],
            h[k[6:4]]   ? {b[4], b[5]} : b[5:4],
            h[k[10:8]]  ? {b[2], b[3]} : b[3:2],
            h[k[14:12]] ? {b[0], b[1]} : b[1:0]};
endfunction

// expected dout for one bus sample under a full 88-bit key.
function automatic logic [7:0] ref_expect(input logic m1_n, input logic rd_n,
                                          input logic mreq_n, input logic en,
                                          input logic [15:0] addr, input logic [7:0] din,
                                          input logic [kabuki_pkg::key_w-1:0] key);
    logic [31:0] k1;
    logic [31:0] k2;
    logic [15:0] ak;
    logic [7:0]  xk;
    logic [15:0] h;
    logic [7:0]  d;
    k1 = key[kabuki_pkg::swap_key1_lsb +: kabuki_pkg::swap_key_w];
    k2 = key[kabuki_pkg::swap_key2_lsb +: kabuki_pkg::swap_key_w];
    ak = key[kabuki_pkg::addr_key_lsb +: kabuki_pkg::addr_key_w];
    xk = key[kabuki_pkg::xor_key_lsb +: kabuki_pkg::xor_key_w];
    if (mreq_n || rd_n || !en) return din;   // not a keyed read, so the byte is unchanged.
    h = ref_hash(m1_n, addr, ak);
    d = ref_swap_fwd(din, k1[15:0], h[7:0]);
    d = {d[6:0], d[7]};
    d = ref_swap_rev(d, k1[31:16], h[7:0]);
    d = d ^ xk;
    d = {d[6:0], d[7]};
    d = ref_swap_rev(d, k2[15:0], h[15:8]);
    d = {d[6:0], d[7]};
    d = ref_swap_fwd(d, k2[31:16], h[15:8]);
    return d;
endfunction

`endif

// ==== sim/kabuki_tb.sv ====
// testbench for the kabuki decryption path; drives bus and key port and checks dout against a model.
`timescale 1ns/1ps
`default_nettype none

module kabuki_tb;

    `include "kabuki_ref.svh"

    // lengths of the test phases in clocks, used to bound the run.
    localparam int reset_cycles = 2;
    localparam int key_cycles = 2 * kabuki_pkg::key_bytes;   // two clocks per key byte.
    localparam int opcode_reads = 300;
    localparam int data_reads = 300;
    localparam int bypass_cycles = 200;
    localparam int reload_reads = 100;
    localparam int mixed_cycles = 500;
    localparam int tail_cycles = 8;   // idle drain and the final wait.
    localparam int stim_cycles = reset_cycles + 1 + key_cycles + opcode_reads + data_reads
                                 + bypass_cycles + key_cycles + reload_reads + mixed_cycles
                                 + tail_cycles;
    localparam int cycle_limit = stim_cycles + 100;

    logic        clk;
    logic        arst_n;
    logic        m1_n;
    logic        rd_n;
    logic        mreq_n;
    logic        en;
    logic [15:0] addr;
    logic [7:0]  din;
    logic [7:0]  prog_data;
    logic        prog_we;
    logic [7:0]  dout;

    int cycle_cnt = 0;     // clocks since time zero.
    int checks = 0;        // dout values compared.
    int dout_errors = 0;   // dout mismatches seen by the checker.
    int misc_errors = 0;   // any other failure.

    logic [31:0] r;         // random word for the main stimulus.
    logic [1:0]  kind;      // which pass-through case a cycle uses.

    // the model's own copy of the key and of the write strobe history.
    logic [kabuki_pkg::key_w-1:0] model_key;
    logic                         model_last_we;

    // bus sample held for one clock, as stage one does.
    logic        s1_valid;
    logic        s1_m1;
    logic        s1_rd;
    logic        s1_mreq;
    logic        s1_en;
    logic [15:0] s1_addr;
    logic [7:0]  s1_din;
    logic [15:0] s1_ak;     // address key in force when the sample was taken.

    logic [7:0] exp_q[$];   // expected dout values, oldest first.
    logic [7:0] exp_v;

    kabuki_decoder_top i_kabuki_decoder_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .m1_n      (m1_n),
        .rd_n      (rd_n),
        .mreq_n    (mreq_n),
        .en        (en),
        .addr      (addr),
        .din       (din),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .dout      (dout)
    );

    always #10 clk = ~clk;   // 20 ns period.

    // one bus cycle, driven just after the rising edge.
    task automatic step(input logic m1, input logic rd, input logic mreq, input logic e,
                        input logic [15:0] a, input logic [7:0] d,
                        input logic we, input logic [7:0] pd);
        @(posedge clk);
        m1_n      <= m1;
        rd_n      <= rd;
        mreq_n    <= mreq;
        en        <= e;
        addr      <= a;
        din       <= d;
        prog_we   <= we;
        prog_data <= pd;
    endtask

    // writes eleven random key bytes, each as a high then a low clock on prog_we.
    task automatic load_key(input logic with_reads);
        logic [31:0] rk;
        logic [31:0] rb;
        for (int i = 0; i < kabuki_pkg::key_bytes; i++) begin
            rk = $urandom();
            rb = $urandom();
            // the byte on the high clock is a decoy; only the low clock's byte is taken.
            step(rb[24], !with_reads, !with_reads, with_reads, rb[15:0], rb[23:16],
                 1'b1, rk[15:8]);
            rb = $urandom();
            step(rb[24], !with_reads, !with_reads, with_reads, rb[15:0], rb[23:16],
                 1'b0, rk[7:0]);
        end
    endtask

    // model of the pipeline timing; it reads the inputs as they stand before the edge.
    always @(posedge clk) begin : model
        logic [kabuki_pkg::key_w-1:0] k;
        if (!arst_n) begin
            model_key     = '0;
            model_last_we = 1'b0;
            s1_valid      = 1'b0;
        end else begin
            if (s1_valid) begin
                // stage two uses today's swap and xor keys with the address key of the sample.
                k = model_key;
                k[kabuki_pkg::addr_key_lsb +: kabuki_pkg::addr_key_w] = s1_ak;
                exp_q.push_back(ref_expect(s1_m1, s1_rd, s1_mreq, s1_en, s1_addr, s1_din, k));
            end
            s1_valid = 1'b1;
            s1_m1    = m1_n;
            s1_rd    = rd_n;
            s1_mreq  = mreq_n;
            s1_en    = en;
            s1_addr  = addr;
            s1_din   = din;
            s1_ak    = model_key[kabuki_pkg::addr_key_lsb +: kabuki_pkg::addr_key_w];
            if (model_last_we && !prog_we) begin
                model_key = {model_key[kabuki_pkg::key_w-9:0], prog_data};   // shift in.
            end
            model_last_we = prog_we;
        end
    end

    // dout is stable at the falling edge, half a clock after it was registered.
    always @(negedge clk) begin
        if (exp_q.size() > 0) begin
            exp_v = exp_q.pop_front();
            checks++;
            assert (dout === exp_v) else begin
                dout_errors++;
                $display("MISMATCH dout expected %h got %h at %0t", exp_v, dout, $time);
            end
        end
    end

    // stops a run that goes on past its expected length.
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d clocks", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(56842));
        clk       = 1'b0;
        arst_n    = 1'b0;
        m1_n      = 1'b1;
        rd_n      = 1'b1;
        mreq_n    = 1'b1;
        en        = 1'b0;
        addr      = 16'h0000;
        din       = 8'h00;
        prog_data = 8'h00;
        prog_we   = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        arst_n <= 1'b1;

        // dout comes out of reset as zero.
        @(negedge clk);
        assert (dout === 8'h00) else begin
            misc_errors++;
            $display("MISMATCH dout expected %h got %h after reset", 8'h00, dout);
        end

        // first key with the bus idle, then opcode fetches back to back.
        load_key(1'b0);
        repeat (opcode_reads) begin
            r = $urandom();
            step(1'b0, 1'b0, 1'b0, 1'b1, r[15:0], r[23:16], 1'b0, 8'h00);
        end

        // data reads under the same key.
        repeat (data_reads) begin
            r = $urandom();
            step(1'b1, 1'b0, 1'b0, 1'b1, r[15:0], r[23:16], 1'b0, 8'h00);
        end

        // cycles that must not be decrypted.
        repeat (bypass_cycles) begin
            r = $urandom();
            kind = r[25:24];
            step(r[26], kind == 2'd1 || kind == 2'd3, kind == 2'd2 || kind == 2'd3,
                 kind != 2'd0 && kind != 2'd3, r[15:0], r[23:16], 1'b0, 8'h00);
        end

        // new key written while reads keep going.
        load_key(1'b1);
        repeat (reload_reads) begin
            r = $urandom();
            step(r[24], 1'b0, 1'b0, 1'b1, r[15:0], r[23:16], 1'b0, 8'h00);
        end

        // everything random on the bus.
        repeat (mixed_cycles) begin
            r = $urandom();
            step(r[24], r[25], r[26], r[27], r[15:0], r[23:16], 1'b0, 8'h00);
        end

        // idle bus, then wait until the last item has been compared.
        repeat (3) step(1'b1, 1'b1, 1'b1, 1'b0, 16'h0000, 8'h00, 1'b0, 8'h00);
        repeat (4) @(posedge clk);

        $display("checks: %0d, dout mismatches: %0d, other errors: %0d",
                 checks, dout_errors, misc_errors);
        if (dout_errors == 0 && misc_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : kabuki_tb

`default_nettype wire

// ==== verilog/kabuki_addr_hash.sv ====
// first pipeline stage; hashes the cpu address with the address key and registers it with the bus byte.
`timescale 1ns/1ps
`default_nettype none

module kabuki_addr_hash (
    input  wire logic                               clk,
    input  wire logic                               arst_n,
    input  wire logic                               m1_n,    // low on an opcode fetch.
    input  wire logic                               rd_n,
    input  wire logic                               mreq_n,
    input  wire logic                               en,      // decryption enable.
    input  wire logic [15:0]                        addr,
    input  wire logic [7:0]                         din,     // byte from the rom.
    input  wire logic [kabuki_pkg::addr_key_w-1:0]  addr_key,
    output logic      [15:0]                        addr_hit, // hash, drives the swap selects.
    output logic                                    decrypt,  // this item is a keyed memory read.
    output logic      [7:0]                         byte_q    // bus byte, aligned with the hash.
);

    logic [15:0] op_hash;    // hash used on opcode fetches.
    logic [15:0] data_hash;  // hash used on data reads.
    logic [15:0] hash_d;     // hash chosen for this cycle.
    logic        decrypt_d;  // qualifier before the register.

    // an opcode fetch only adds the key to the address.
    assign op_hash = addr + addr_key;

    // a data read masks the address first, then adds the key and one.
    assign data_hash = (addr ^ kabuki_pkg::data_addr_mask) + addr_key
                       + kabuki_pkg::data_addr_inc;

    // m1_n picks which of the two hashes goes forward.
    assign hash_d = m1_n ? data_hash : op_hash;

    // only a memory read with the enable set is decrypted.
    // i/o cycles, writes and idle cycles pass through.
    assign decrypt_d = !mreq_n && !rd_n && en;

    // the qualifier is the only control bit in this stage.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decrypt <= 1'b0;
        end else begin
            decrypt <= decrypt_d;
        end
    end

    // hash and byte are loaded every clock alongside the qualifier.
    // stage two then sees all three from the same bus cycle.
    always_ff @(posedge clk) begin
        addr_hit <= hash_d;
        byte_q   <= din;
    end

    // there is no valid bit and no stall.
    // every clock carries one item, whether it is decrypted or not.

endmodule : kabuki_addr_hash

`default_nettype wire

// ==== verilog/kabuki_byte_decrypt.sv ====
// second pipeline stage; applies the keyed bit-pair swaps, rotations and xor, and registers dout.
`timescale 1ns/1ps
`default_nettype none

module kabuki_byte_decrypt (
    input  wire logic                               clk,
    input  wire logic                               arst_n,
    input  wire logic [7:0]                         byte_q,    // bus byte from stage one.
    input  wire logic                               decrypt,   // high when the byte is keyed.
    input  wire logic [15:0]                        addr_hit,  // address hash from stage one.
    input  wire logic [kabuki_pkg::swap_key_w-1:0]  swap_key1,
    input  wire logic [kabuki_pkg::swap_key_w-1:0]  swap_key2,
    input  wire logic [kabuki_pkg::xor_key_w-1:0]   xor_key,
    output logic      [7:0]                         dout
);

    logic [7:0] dec;  // cipher result before the output register.

    // swaps each bit pair when the hash bit selected by its key nibble is set.
    // key[14:12] goes with the top pair and key[2:0] with the bottom pair.
    function automatic logic [7:0] swap_fwd(
        input logic [7:0]  b,
        input logic [15:0] key,
        input logic [7:0]  hit
    );
        logic [7:0] r;
        r = b;
        if (hit[key[14:12]]) r[7:6] = {b[6], b[7]};
        if (hit[key[10:8]])  r[5:4] = {b[4], b[5]};
        if (hit[key[6:4]])   r[3:2] = {b[2], b[3]};
        if (hit[key[2:0]])   r[1:0] = {b[0], b[1]};
        return r;
    endfunction

    // same swap with the nibble order reversed.
    // key[2:0] now goes with the top pair.
    function automatic logic [7:0] swap_rev(
        input logic [7:0]  b,
        input logic [15:0] key,
        input logic [7:0]  hit
    );
        logic [7:0] r;
        r = b;
        if (hit[key[2:0]])   r[7:6] = {b[6], b[7]};
        if (hit[key[6:4]])   r[5:4] = {b[4], b[5]};
        if (hit[key[10:8]])  r[3:2] = {b[2], b[3]};
        if (hit[key[14:12]]) r[1:0] = {b[0], b[1]};
        return r;
    endfunction

    // rotate left by the package amount.
    function automatic logic [7:0] rol(input logic [7:0] b);
        return (b << kabuki_pkg::rot_amount) | (b >> (8 - kabuki_pkg::rot_amount));
    endfunction

    // the eight cipher steps in sequence.
    // the low hash byte drives swap key one and the high hash byte drives swap key two.
    always_comb begin
        dec = byte_q;
        if (decrypt) begin
            dec = swap_fwd(dec, swap_key1[15:0], addr_hit[7:0]);    // step 1.
            dec = rol(dec);                                          // step 2.
            dec = swap_rev(dec, swap_key1[31:16], addr_hit[7:0]);   // step 3.
            dec = dec ^ xor_key;                                     // step 4.
            dec = rol(dec);                                          // step 5.
            dec = swap_rev(dec, swap_key2[15:0], addr_hit[15:8]);   // step 6.
            dec = rol(dec);                                          // step 7.
            dec = swap_fwd(dec, swap_key2[31:16], addr_hit[15:8]);  // step 8.
        end
    end

    // dout is the second pipeline register.
    // it reads zero until the first item comes out of reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout <= 8'h00;
        end else begin
            dout <= dec;
        end
    end

endmodule : kabuki_byte_decrypt

`default_nettype wire

// ==== verilog/kabuki_decoder_top.sv ====
// top level of the kabuki decryption path; joins the key loader and the two pipeline stages.
`timescale 1ns/1ps
`default_nettype none

module kabuki_decoder_top (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        m1_n,       // cpu bus strobes and levels.
    input  wire logic        rd_n,
    input  wire logic        mreq_n,
    input  wire logic        en,         // decryption on or off.
    input  wire logic [15:0] addr,
    input  wire logic [7:0]  din,        // rom byte.
    input  wire logic [7:0]  prog_data,  // key programming port.
    input  wire logic        prog_we,
    output logic      [7:0]  dout        // decrypted byte, two clocks after the bus sample.
);

    // key fields, held steady by the loader.
    logic [kabuki_pkg::swap_key_w-1:0] swap_key1;
    logic [kabuki_pkg::swap_key_w-1:0] swap_key2;
    logic [kabuki_pkg::addr_key_w-1:0] addr_key;
    logic [kabuki_pkg::xor_key_w-1:0]  xor_key;

    // items passed from stage one to stage two.
    logic [15:0] addr_hit;
    logic        decrypt;
    logic [7:0]  byte_q;

    kabuki_key_loader i_kabuki_key_loader (
        .clk       (clk),
        .arst_n    (arst_n),
        .prog_data (prog_data),
        .prog_we   (prog_we),
        .swap_key1 (swap_key1),
        .swap_key2 (swap_key2),
        .addr_key  (addr_key),
        .xor_key   (xor_key)
    );

    // stage one only needs the address key.
    kabuki_addr_hash i_kabuki_addr_hash (
        .clk      (clk),
        .arst_n   (arst_n),
        .m1_n     (m1_n),
        .rd_n     (rd_n),
        .mreq_n   (mreq_n),
        .en       (en),
        .addr     (addr),
        .din      (din),
        .addr_key (addr_key),
        .addr_hit (addr_hit),
        .decrypt  (decrypt),
        .byte_q   (byte_q)
    );

    // stage two takes the swap keys and the xor key.
    kabuki_byte_decrypt i_kabuki_byte_decrypt (
        .clk       (clk),
        .arst_n    (arst_n),
        .byte_q    (byte_q),
        .decrypt   (decrypt),
        .addr_hit  (addr_hit),
        .swap_key1 (swap_key1),
        .swap_key2 (swap_key2),
        .xor_key   (xor_key),
        .dout      (dout)
    );

endmodule : kabuki_decoder_top

`default_nettype wire

// ==== verilog/kabuki_key_loader.sv ====
// collects the 88-bit kabuki key from the byte-wide programming port and drives its fields.
`timescale 1ns/1ps
`default_nettype none

module kabuki_key_loader (
    input  wire logic                                clk,
    input  wire logic                                arst_n,
    input  wire logic [7:0]                          prog_data,  // next key byte.
    input  wire logic                                prog_we,    // byte is taken on its fall.
    output logic      [kabuki_pkg::swap_key_w-1:0]   swap_key1,
    output logic      [kabuki_pkg::swap_key_w-1:0]   swap_key2,
    output logic      [kabuki_pkg::addr_key_w-1:0]   addr_key,
    output logic      [kabuki_pkg::xor_key_w-1:0]    xor_key
);

    logic [kabuki_pkg::key_w-1:0] key_q;   // whole key, last byte written sits at the bottom.
    logic                         last_we; // prog_we as seen on the previous clock.
    logic                         we_fall; // high on the clock where prog_we has just dropped.

    // a falling edge is prog_we high one clock and low the next.
    assign we_fall = last_we && !prog_we;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_we <= 1'b0;
            key_q   <= '0;   // an all-zero key until the loader has run.
        end else begin
            last_we <= prog_we;
            if (we_fall) begin
                // older bytes move up one byte lane.
                // the byte on the bus now fills the low lane.
                key_q <= {key_q[kabuki_pkg::key_w-9:0], prog_data};
            end
        end
    end

    // the fields are plain slices of the register.
    // both stages therefore see the new key one clock after the edge is detected.
    assign swap_key1 = key_q[kabuki_pkg::swap_key1_lsb +: kabuki_pkg::swap_key_w];
    assign swap_key2 = key_q[kabuki_pkg::swap_key2_lsb +: kabuki_pkg::swap_key_w];
    assign addr_key  = key_q[kabuki_pkg::addr_key_lsb +: kabuki_pkg::addr_key_w];
    assign xor_key   = key_q[kabuki_pkg::xor_key_lsb +: kabuki_pkg::xor_key_w];

    // a partly written key is used as it stands.
    // the cpu is normally held until all eleven bytes are in.

endmodule : kabuki_key_loader

`default_nettype wire

// ==== verilog/kabuki_pkg.sv ====
// shared key layout and address hash constants for the kabuki decryption path and its testbench.
`default_nettype none

package kabuki_pkg;

    // the key is written one programming byte at a time, most significant byte first.
    localparam int key_bytes = 11;
    localparam int key_w = key_bytes * 8;   // 88 bits in total.

    // widths of the four key fields.
    // they are packed from the msb down as swap key one, swap key two, address key, xor key.
    localparam int swap_key_w = 32;   // each swap key holds two 16-bit nibble sets.
    localparam int addr_key_w = 16;   // added to the cpu address to form the hash.
    localparam int xor_key_w = 8;     // xored into the byte halfway through the cipher.

    // bit positions of each field inside the key register, derived from the widths above.
    localparam int xor_key_lsb = 0;
    localparam int addr_key_lsb = xor_key_lsb + xor_key_w;
    localparam int swap_key2_lsb = addr_key_lsb + addr_key_w;
    localparam int swap_key1_lsb = swap_key2_lsb + swap_key_w;

    // data reads scramble the address with this mask before the key is added.
    // opcode fetches use the raw address.
    localparam logic [15:0] data_addr_mask = 16'h1fc0;

    // data reads also add one after the key.
    localparam logic [15:0] data_addr_inc = 16'd1;

    // the cipher rotates the byte three times.
    // each rotation moves bit 7 around to bit 0.
    localparam int rot_amount = 1;

endpackage : kabuki_pkg

`default_nettype wire
